// File: verilog/core_params_pkg.sv
`default_nettype none

// Sizes shared by the rename and commit logic
package core_params_pkg;

    localparam int SS = 2;                  // Instructions per dispatch group

    // Register files
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Queue depths
    localparam int ROB_DEPTH = 8;
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;  // Regs unmapped at reset

    // Index widths
    localparam int ARCH_W = $clog2(ARCH_REGS);
    localparam int PHYS_W = $clog2(PHYS_REGS);
    localparam int ROB_W = $clog2(ROB_DEPTH);

endpackage : core_params_pkg

`default_nettype wire

// File: verilog/rv32i_types.sv
`default_nettype none

package rv32i_types;
    import core_params_pkg::*;

    // Reset contents of a circular_queue
    typedef enum logic {
        ZERO,                               // Cleared and empty
        FREE_LIST                           // Holds regs 32 and up, full
    } initialization_t;

    typedef logic [PHYS_W-1:0] phys_reg_t;

    // One reorder buffer slot, 17 bits
    typedef struct packed {
        logic [ARCH_W-1:0] rd;              // Architectural destination
        phys_reg_t phys_rd;                 // Mapping given at rename
        phys_reg_t old_phys;                // Mapping it replaced
    } rob_entry_t;

endpackage : rv32i_types

`default_nettype wire

// File: verilog/rob_alloc_if.sv
`timescale 1ns/1ps
`default_nettype none

// Group allocation from rename into the reorder buffer
interface rob_alloc_if;
    import core_params_pkg::*;
    import rv32i_types::*;

    logic alloc;                            // Group accepted this cycle
    rob_entry_t entry [SS];
    logic [ROB_W-1:0] rob_idx;              // Slot of entry[0]
    logic rob_full;

    modport rename (
        output alloc, entry,
        input rob_idx, rob_full
    );

    modport rob (
        input alloc, entry,
        output rob_idx, rob_full
    );

endinterface : rob_alloc_if

`default_nettype wire

// File: verilog/circular_queue.sv
`timescale 1ns/1ps
`default_nettype none

module circular_queue #(
    type QUEUE_TYPE = rv32i_types::phys_reg_t,
    parameter rv32i_types::initialization_t INIT_TYPE = rv32i_types::ZERO,
    parameter int DEPTH = 8,
    parameter int SS = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  QUEUE_TYPE in [SS],
    output logic empty,
    output logic full,
    output logic [$clog2(DEPTH)-1:0] head_out,
    output logic [$clog2(DEPTH)-1:0] tail_out,
    output QUEUE_TYPE out [SS],
    output QUEUE_TYPE peek [SS]
);
    import core_params_pkg::*;
    import rv32i_types::*;

    // Pointers carry one wrap bit above the index
    logic [$clog2(DEPTH):0] head;
    logic [$clog2(DEPTH):0] tail;
    logic [$clog2(DEPTH)-1:0] wr_idx [SS];
    logic [$clog2(DEPTH)-1:0] rd_idx [SS];
    QUEUE_TYPE entries [DEPTH];

    assign head_out = head[$clog2(DEPTH)-1:0];
    assign tail_out = tail[$clog2(DEPTH)-1:0];

    // Same index, different lap means full
    assign empty = (head == tail);
    assign full = (head_out == tail_out) && (head[$clog2(DEPTH)] != tail[$clog2(DEPTH)]);

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            wr_idx[i] = head_out + ($clog2(DEPTH))'(i);   // Wraps at DEPTH
            rd_idx[i] = tail_out + ($clog2(DEPTH))'(i);
            peek[i] = entries[rd_idx[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            if (INIT_TYPE == FREE_LIST) begin
                // Start one lap ahead so the queue reads full
                head <= {1'b1, {$clog2(DEPTH){1'b0}}};
                for (int k = 0; k < DEPTH; k++) begin
                    entries[k] <= ($bits(QUEUE_TYPE))'(ARCH_REGS + k);
                end
            end else begin
                head <= '0;
                for (int k = 0; k < DEPTH; k++) begin
                    entries[k] <= '0;
                end
            end
        end else begin
            if (push) begin
                for (int i = 0; i < SS; i++) begin
                    entries[wr_idx[i]] <= in[i];
                end
                head <= head + ($clog2(DEPTH)+1)'(SS);
            end
            if (pop) begin
                for (int i = 0; i < SS; i++) begin
                    out[i] <= entries[rd_idx[i]];       // Held until next pop
                end
                tail <= tail + ($clog2(DEPTH)+1)'(SS);
            end
        end
    end

endmodule : circular_queue

`default_nettype wire

// File: verilog/rename_map.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  logic clk,
    input  logic rst,
    input  logic disp_valid,
    input  logic [core_params_pkg::ARCH_W-1:0] rs1_arch [core_params_pkg::SS],
    input  logic [core_params_pkg::ARCH_W-1:0] rs2_arch [core_params_pkg::SS],
    input  logic [core_params_pkg::ARCH_W-1:0] rd_arch [core_params_pkg::SS],
    input  logic free_valid,
    input  rv32i_types::phys_reg_t free_phys [core_params_pkg::SS],
    output logic disp_ready,
    output logic ren_valid,
    output rv32i_types::phys_reg_t ren_rs1 [core_params_pkg::SS],
    output rv32i_types::phys_reg_t ren_rs2 [core_params_pkg::SS],
    output rv32i_types::phys_reg_t ren_rd [core_params_pkg::SS],
    output logic [core_params_pkg::ROB_W-1:0] ren_rob_idx [core_params_pkg::SS],
    rob_alloc_if.rename alloc
);
    import core_params_pkg::*;
    import rv32i_types::*;

    phys_reg_t map_table [ARCH_REGS];
    phys_reg_t new_rd [SS];                 // Free-list tail pair
    phys_reg_t src1 [SS];
    phys_reg_t src2 [SS];
    phys_reg_t old_rd [SS];
    logic fl_empty;
    logic accept;

    circular_queue #(
        .QUEUE_TYPE(phys_reg_t),
        .INIT_TYPE(FREE_LIST),
        .DEPTH(FREE_DEPTH),
        .SS(SS)
    ) free_list (
        .clk(clk),
        .rst(rst),
        .push(free_valid),
        .pop(accept),
        .in(free_phys),
        .empty(fl_empty),
        .full(),
        .head_out(),
        .tail_out(),
        .out(),
        .peek(new_rd)
    );

    assign disp_ready = !alloc.rob_full && !fl_empty;
    assign accept = disp_valid && disp_ready;   // Strobes while not ready are dropped

    // Table lookup, then forward from earlier slots of the same group
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            src1[i] = map_table[rs1_arch[i]];
            src2[i] = map_table[rs2_arch[i]];
            old_rd[i] = map_table[rd_arch[i]];
            for (int j = 0; j < i; j++) begin     // Youngest earlier writer wins
                if (rs1_arch[i] == rd_arch[j]) src1[i] = new_rd[j];
                if (rs2_arch[i] == rd_arch[j]) src2[i] = new_rd[j];
                if (rd_arch[i] == rd_arch[j]) old_rd[i] = new_rd[j];
            end
        end
    end

    assign alloc.alloc = accept;

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            alloc.entry[i] = '{rd: rd_arch[i], phys_rd: new_rd[i], old_phys: old_rd[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= 1'b0;
            for (int a = 0; a < ARCH_REGS; a++) begin
                map_table[a] <= PHYS_W'(a);     // Identity mapping
            end
        end else begin
            ren_valid <= accept;
            if (accept) begin
                for (int i = 0; i < SS; i++) begin
                    map_table[rd_arch[i]] <= new_rd[i];   // Later slot overrides
                end
            end
        end
    end

    // Rename results for the accepted group
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < SS; i++) begin
                ren_rs1[i] <= src1[i];
                ren_rs2[i] <= src2[i];
                ren_rd[i] <= new_rd[i];
                ren_rob_idx[i] <= alloc.rob_idx + ROB_W'(i);
            end
        end
    end

endmodule : rename_map

`default_nettype wire

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic clk,
    input  logic rst,
    input  logic wb_valid,
    input  logic [core_params_pkg::ROB_W-1:0] wb_rob_idx,
    output logic free_valid,
    output rv32i_types::phys_reg_t free_phys [core_params_pkg::SS],
    output logic commit_valid,
    output logic [core_params_pkg::ARCH_W-1:0] commit_rd [core_params_pkg::SS],
    output rv32i_types::phys_reg_t commit_phys [core_params_pkg::SS],
    rob_alloc_if.rob alloc
);
    import core_params_pkg::*;
    import rv32i_types::*;

    rob_entry_t popped [SS];                // Pair retired last pop
    logic [ROB_DEPTH-1:0] done;             // Written back, one per slot
    logic [ROB_W-1:0] tail_idx;
    logic rob_empty;
    logic tail_done;
    logic commit_now;

    circular_queue #(
        .QUEUE_TYPE(rob_entry_t),
        .INIT_TYPE(ZERO),
        .DEPTH(ROB_DEPTH),
        .SS(SS)
    ) rob_q (
        .clk(clk),
        .rst(rst),
        .push(alloc.alloc),
        .pop(commit_now),
        .in(alloc.entry),
        .empty(rob_empty),
        .full(alloc.rob_full),
        .head_out(alloc.rob_idx),
        .tail_out(tail_idx),
        .out(popped),
        .peek()
    );

    // Whole tail pair must be done
    always_comb begin
        tail_done = 1'b1;
        for (int i = 0; i < SS; i++) begin
            tail_done = tail_done && done[tail_idx + ROB_W'(i)];
        end
    end

    assign commit_now = !rob_empty && tail_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_now;
            if (alloc.alloc) begin
                for (int i = 0; i < SS; i++) begin
                    done[alloc.rob_idx + ROB_W'(i)] <= 1'b0;  // Fresh slots
                end
            end
            if (wb_valid) done[wb_rob_idx] <= 1'b1;
        end
    end

    // Retired pair goes out as commit and free return together
    assign free_valid = commit_valid;

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            commit_rd[i] = popped[i].rd;
            commit_phys[i] = popped[i].phys_rd;
            free_phys[i] = popped[i].old_phys;  // Slot 0 lands first in free list
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// File: verilog/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic clk,
    input  logic rst,
    // Dispatch
    input  logic disp_valid,
    input  logic [core_params_pkg::ARCH_W-1:0] rs1_arch [core_params_pkg::SS],
    input  logic [core_params_pkg::ARCH_W-1:0] rs2_arch [core_params_pkg::SS],
    input  logic [core_params_pkg::ARCH_W-1:0] rd_arch [core_params_pkg::SS],
    output logic disp_ready,
    // Rename results
    output logic ren_valid,
    output rv32i_types::phys_reg_t ren_rs1 [core_params_pkg::SS],
    output rv32i_types::phys_reg_t ren_rs2 [core_params_pkg::SS],
    output rv32i_types::phys_reg_t ren_rd [core_params_pkg::SS],
    output logic [core_params_pkg::ROB_W-1:0] ren_rob_idx [core_params_pkg::SS],
    // Writeback and commit
    input  logic wb_valid,
    input  logic [core_params_pkg::ROB_W-1:0] wb_rob_idx,
    output logic commit_valid,
    output logic [core_params_pkg::ARCH_W-1:0] commit_rd [core_params_pkg::SS],
    output rv32i_types::phys_reg_t commit_phys [core_params_pkg::SS]
);
    import core_params_pkg::*;
    import rv32i_types::*;

    rob_alloc_if alloc_bus ();

    logic free_valid;                       // Old mappings coming back
    phys_reg_t free_phys [SS];

    rename_map u_rename (
        .clk(clk),
        .rst(rst),
        .disp_valid(disp_valid),
        .rs1_arch(rs1_arch),
        .rs2_arch(rs2_arch),
        .rd_arch(rd_arch),
        .free_valid(free_valid),
        .free_phys(free_phys),
        .disp_ready(disp_ready),
        .ren_valid(ren_valid),
        .ren_rs1(ren_rs1),
        .ren_rs2(ren_rs2),
        .ren_rd(ren_rd),
        .ren_rob_idx(ren_rob_idx),
        .alloc(alloc_bus.rename)
    );

    reorder_buffer u_rob (
        .clk(clk),
        .rst(rst),
        .wb_valid(wb_valid),
        .wb_rob_idx(wb_rob_idx),
        .free_valid(free_valid),
        .free_phys(free_phys),
        .commit_valid(commit_valid),
        .commit_rd(commit_rd),
        .commit_phys(commit_phys),
        .alloc(alloc_bus.rob)
    );

endmodule : rename_core

`default_nettype wire

// File: dv/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;
    import core_params_pkg::*;
    import rv32i_types::*;

    typedef struct packed {
        logic [SS-1:0][ARCH_W-1:0] rs1;
        logic [SS-1:0][ARCH_W-1:0] rs2;
        logic [SS-1:0][ARCH_W-1:0] rd;
    } group_t;

    typedef struct packed {
        logic [SS-1:0][PHYS_W-1:0] rs1;
        logic [SS-1:0][PHYS_W-1:0] rs2;
        logic [SS-1:0][PHYS_W-1:0] rd;
        logic [SS-1:0][PHYS_W-1:0] old;
    } renamed_t;

    typedef struct packed {
        logic [ARCH_W-1:0] rd;
        phys_reg_t phys_rd;
        phys_reg_t old_phys;
        logic [ROB_W-1:0] idx;
    } rob_rec_t;

    logic clk = 1'b0;
    logic rst;
    logic disp_valid;
    logic [ARCH_W-1:0] rs1_arch [SS];
    logic [ARCH_W-1:0] rs2_arch [SS];
    logic [ARCH_W-1:0] rd_arch [SS];
    logic disp_ready;
    logic ren_valid;
    phys_reg_t ren_rs1 [SS];
    phys_reg_t ren_rs2 [SS];
    phys_reg_t ren_rd [SS];
    logic [ROB_W-1:0] ren_rob_idx [SS];
    logic wb_valid;
    logic [ROB_W-1:0] wb_rob_idx;
    logic commit_valid;
    logic [ARCH_W-1:0] commit_rd [SS];
    phys_reg_t commit_phys [SS];

    // Model of the rename state
    phys_reg_t model_map [ARCH_REGS];
    phys_reg_t model_free [$];
    rob_rec_t model_rob [$];
    group_t sent_q [$];                     // Accepted, rename not seen yet
    logic [ROB_W-1:0] wb_pool [$];          // Allocated, no writeback yet
    logic [ROB_DEPTH-1:0] wb_done;
    logic [ROB_W-1:0] model_rob_idx;
    integer seed;
    int errors;
    int groups_seen;
    int commits_seen;
    int commit_stall;

    rename_core DUT (
        .clk(clk),
        .rst(rst),
        .disp_valid(disp_valid),
        .rs1_arch(rs1_arch),
        .rs2_arch(rs2_arch),
        .rd_arch(rd_arch),
        .disp_ready(disp_ready),
        .ren_valid(ren_valid),
        .ren_rs1(ren_rs1),
        .ren_rs2(ren_rs2),
        .ren_rd(ren_rd),
        .ren_rob_idx(ren_rob_idx),
        .wb_valid(wb_valid),
        .wb_rob_idx(wb_rob_idx),
        .commit_valid(commit_valid),
        .commit_rd(commit_rd),
        .commit_phys(commit_phys)
    );

    always #50 clk = ~clk;

    // Expected rename of one group, updates the model table and free list
    function automatic renamed_t rename_group(ref phys_reg_t table_m [ARCH_REGS],
                                              ref phys_reg_t fifo [$], input group_t g);
        renamed_t r;
        r.rd[0] = fifo.pop_front();         // Oldest free regs first
        r.rd[1] = fifo.pop_front();
        r.rs1[0] = table_m[g.rs1[0]];
        r.rs2[0] = table_m[g.rs2[0]];
        r.old[0] = table_m[g.rd[0]];
        // Slot 1 sees slot 0's new register
        r.rs1[1] = (g.rs1[1] == g.rd[0]) ? r.rd[0] : table_m[g.rs1[1]];
        r.rs2[1] = (g.rs2[1] == g.rd[0]) ? r.rd[0] : table_m[g.rs2[1]];
        r.old[1] = (g.rd[1] == g.rd[0]) ? r.rd[0] : table_m[g.rd[1]];
        table_m[g.rd[0]] = r.rd[0];
        table_m[g.rd[1]] = r.rd[1];         // Slot 1 wins on equal rd
        return r;
    endfunction

    function automatic group_t make_group(input int a0, input int b0, input int d0,
                                          input int a1, input int b1, input int d1);
        group_t g;
        g.rs1[0] = ARCH_W'(a0);
        g.rs2[0] = ARCH_W'(b0);
        g.rd[0] = ARCH_W'(d0);
        g.rs1[1] = ARCH_W'(a1);
        g.rs2[1] = ARCH_W'(b1);
        g.rd[1] = ARCH_W'(d1);
        return g;
    endfunction

    function automatic group_t random_group();
        group_t g;
        for (int i = 0; i < SS; i++) begin
            g.rs1[i] = ARCH_W'($random(seed));
            g.rs2[i] = ARCH_W'($random(seed));
            g.rd[i] = ARCH_W'($random(seed));
        end
        return g;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        errors++;
        $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%0t %s", $time, what);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("%0t timeout while waiting for %s", $time, what);
    endtask

    // Compare on the falling edge, where outputs are settled
    always @(negedge clk) begin : compare
        renamed_t exp;
        group_t g;
        rob_rec_t rec;
        logic [ROB_W-1:0] idx_exp;
        if (!rst && ren_valid) begin
            if (sent_q.size() == 0 || model_free.size() < SS) begin
                report_problem("ren_valid without an accepted group");
            end else begin
                g = sent_q.pop_front();
                exp = rename_group(model_map, model_free, g);
                groups_seen++;
                for (int i = 0; i < SS; i++) begin
                    idx_exp = model_rob_idx + ROB_W'(i);
                    if (ren_rs1[i] !== exp.rs1[i])
                        report_mismatch($sformatf("ren_rs1[%0d]", i), int'(exp.rs1[i]),
                                        int'(ren_rs1[i]));
                    if (ren_rs2[i] !== exp.rs2[i])
                        report_mismatch($sformatf("ren_rs2[%0d]", i), int'(exp.rs2[i]),
                                        int'(ren_rs2[i]));
                    if (ren_rd[i] !== exp.rd[i])
                        report_mismatch($sformatf("ren_rd[%0d]", i), int'(exp.rd[i]),
                                        int'(ren_rd[i]));
                    if (ren_rob_idx[i] !== idx_exp)
                        report_mismatch($sformatf("ren_rob_idx[%0d]", i), int'(idx_exp),
                                        int'(ren_rob_idx[i]));
                    rec.rd = g.rd[i];
                    rec.phys_rd = exp.rd[i];
                    rec.old_phys = exp.old[i];
                    rec.idx = idx_exp;
                    model_rob.push_back(rec);
                    wb_pool.push_back(idx_exp);
                end
                model_rob_idx += ROB_W'(SS);
            end
        end
        if (!rst && commit_valid) begin
            commit_stall = 0;
            commits_seen++;
            if (model_rob.size() < SS) begin
                report_problem("commit_valid with no allocated pair");
            end else begin
                for (int i = 0; i < SS; i++) begin
                    rec = model_rob.pop_front();
                    if (!wb_done[rec.idx]) report_problem("commit before writeback");
                    if (commit_rd[i] !== rec.rd)
                        report_mismatch($sformatf("commit_rd[%0d]", i), int'(rec.rd),
                                        int'(commit_rd[i]));
                    if (commit_phys[i] !== rec.phys_rd)
                        report_mismatch($sformatf("commit_phys[%0d]", i), int'(rec.phys_rd),
                                        int'(commit_phys[i]));
                    model_free.push_back(rec.old_phys);     // Slot 0 first
                    wb_done[rec.idx] = 1'b0;
                end
            end
        end else if (model_rob.size() >= SS && wb_done[model_rob[0].idx]
                     && wb_done[model_rob[1].idx]) begin
            commit_stall++;
            if (commit_stall == 4) report_problem("tail pair done but no commit");
        end else begin
            commit_stall = 0;
        end
    end

    // Strobes last one cycle, inputs change 10 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
        disp_valid = 1'b0;
        wb_valid = 1'b0;
    endtask

    task automatic drive_group(input group_t g);
        disp_valid = 1'b1;
        for (int i = 0; i < SS; i++) begin
            rs1_arch[i] = g.rs1[i];
            rs2_arch[i] = g.rs2[i];
            rd_arch[i] = g.rd[i];
        end
    endtask

    task automatic dispatch(input group_t g);
        int n;
        n = 0;
        next_cycle();
        while (!disp_ready && n < 100) begin
            next_cycle();
            n++;
        end
        if (!disp_ready) begin
            report_timeout("disp_ready");
        end else begin
            drive_group(g);
            sent_q.push_back(g);
        end
    endtask

    task automatic writeback_random();
        int k;
        if (wb_pool.size() > 0) begin
            k = $unsigned($random(seed)) % wb_pool.size();
            wb_valid = 1'b1;
            wb_rob_idx = wb_pool[k];
            wb_done[wb_pool[k]] = 1'b1;
            wb_pool.delete(k);
        end
    endtask

    task automatic wait_renamed();
        int n;
        n = 0;
        while (sent_q.size() > 0 && n < 50) begin
            next_cycle();
            n++;
        end
        if (sent_q.size() > 0) report_timeout("rename results");
    endtask

    // Write back everything in random order until the ROB is empty
    task automatic drain();
        int n;
        n = 0;
        while ((sent_q.size() > 0 || model_rob.size() > 0) && n < 300) begin
            next_cycle();
            writeback_random();
            n++;
        end
        if (sent_q.size() > 0 || model_rob.size() > 0) report_timeout("the ROB to drain");
    endtask

    task automatic end_test(input int num, input string name, input int err_start);
        if (errors == err_start) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: %0d errors", num, name, errors - err_start);
    endtask

    initial begin
        group_t g;
        int err_start;
        seed = 32'hc503_5aa4;
        rst = 1'b1;
        disp_valid = 1'b0;
        wb_valid = 1'b0;
        wb_rob_idx = '0;
        for (int i = 0; i < SS; i++) begin
            rs1_arch[i] = '0;
            rs2_arch[i] = '0;
            rd_arch[i] = '0;
        end
        for (int a = 0; a < ARCH_REGS; a++) model_map[a] = PHYS_W'(a);
        for (int k = 0; k < FREE_DEPTH; k++) model_free.push_back(PHYS_W'(ARCH_REGS + k));
        wb_done = '0;
        model_rob_idx = '0;
        errors = 0;
        groups_seen = 0;
        commits_seen = 0;
        commit_stall = 0;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        // Identity map and first free regs
        err_start = errors;
        if (!disp_ready) report_problem("disp_ready low after reset");
        if (ren_valid || commit_valid) report_problem("valid output high after reset");
        dispatch(make_group(1, 2, 5, 3, 4, 6));
        wait_renamed();
        drain();
        end_test(1, "reset and identity", err_start);

        // Forwarding inside a group
        err_start = errors;
        dispatch(make_group(3, 4, 7, 7, 8, 9));
        dispatch(make_group(7, 9, 10, 10, 1, 10));     // Same rd in both slots
        dispatch(make_group(10, 10, 11, 11, 7, 12));
        wait_renamed();
        drain();
        end_test(2, "group forwarding", err_start);

        // ROB full blocks dispatch
        err_start = errors;
        for (int n = 0; n < ROB_DEPTH / SS; n++) dispatch(random_group());
        next_cycle();
        for (int n = 0; n < 3; n++) begin
            if (disp_ready) report_problem("disp_ready high with the ROB full");
            drive_group(random_group());   // Must be ignored
            next_cycle();
        end
        wait_renamed();
        drain();
        end_test(3, "ROB full", err_start);

        // Out of order writeback
        err_start = errors;
        for (int n = 0; n < ROB_DEPTH / SS; n++) dispatch(random_group());
        wait_renamed();
        drain();
        end_test(4, "random writeback order", err_start);

        // Long run with register reuse
        err_start = errors;
        for (int c = 0; c < 400; c++) begin
            next_cycle();
            if (disp_ready && ($random(seed) & 1)) begin
                g = random_group();
                drive_group(g);
                sent_q.push_back(g);
            end
            if ($random(seed) & 1) writeback_random();
        end
        drain();
        if (groups_seen <= FREE_DEPTH) report_problem("too few groups to reuse freed registers");
        end_test(5, "free list reuse", err_start);

        $display("groups %0d, commits %0d, errors %0d", groups_seen, commits_seen, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : rename_core_tb

`default_nettype wire

// File: list.f
verilog/core_params_pkg.sv
verilog/rv32i_types.sv
verilog/rob_alloc_if.sv
verilog/circular_queue.sv
verilog/rename_map.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
dv/rename_core_tb.sv

// File: Makefile
# Verilator build and run for the rename and commit block

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
